//--- hdl/cgra_conf_pkg.sv
package cgra_conf_pkg;

  // ##########################################################
  // Line and word geometry
  // ##########################################################

  localparam int LINE_W         = 512;
  localparam int WORD_W         = 64;
  localparam int WORDS_PER_LINE = LINE_W / WORD_W;
  localparam int MAX_WORD_COUNT = 1024;

  // ##########################################################
  // Line formats
  // ##########################################################

  typedef struct packed {
    logic [LINE_W-73:0] padding;      // Bits 511 to 72, ignored
    logic [7:0]         write_mask;   // Bits 71 to 64
    logic [23:0]        reserved;     // Bits 63 to 40, ignored
    logic [7:0]         read_mask;    // Bits 39 to 32
    logic [31:0]        word_count;   // Bits 31 to 0
  } conf_header_t;

  // Line 0 is read as a header, every later line as eight words
  typedef union packed {
    conf_header_t                                header;
    logic [WORDS_PER_LINE-1:0][WORD_W-1:0]       words;   // Word 0 sits at the low end
  } conf_line_u;

  // Word count after clamping to what the loader accepts
  function automatic logic [31:0] eff_count(input logic [31:0] word_count);
    return (word_count > 32'(MAX_WORD_COUNT)) ? 32'(MAX_WORD_COUNT) : word_count;
  endfunction

  // Header line plus the word lines, last one possibly partial
  function automatic logic [31:0] line_count(input logic [31:0] word_count);
    logic [31:0] words;
    words = eff_count(word_count);
    return 32'd1 + ((words + 32'(WORDS_PER_LINE - 1)) / 32'(WORDS_PER_LINE));
  endfunction

endpackage

//--- hdl/cgra_arch_pkg.sv
package cgra_arch_pkg;

  // ##########################################################
  // Array geometry
  // ##########################################################

  localparam int NUM_PE  = 16;
  localparam int PE_ID_W = 8;                    // Id field in bits 63 to 56 of a word

  // Index width into the PE register bank
  localparam int PE_IDX_W = (NUM_PE > 1) ? $clog2(NUM_PE) : 1;

  localparam int PE_PAYLOAD_W = 56;              // Word bits below the id field

endpackage

//--- hdl/conf_line_fetch.sv
`timescale 1ns/1ps

module conf_line_fetch #(
  parameter int ADDR_W = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  output logic                       mem_req,
  output logic [ADDR_W-1:0]          mem_addr,
  input  logic                       mem_ack,
  input  cgra_conf_pkg::conf_line_u  mem_line,
  output logic                       push,
  output cgra_conf_pkg::conf_line_u  push_line,
  input  logic                       fifo_full
);

  localparam logic [1:0] F_IDLE    = 2'd0;
  localparam logic [1:0] F_REQ     = 2'd1;
  localparam logic [1:0] F_RELEASE = 2'd2;
  localparam logic [1:0] F_DONE    = 2'd3;

  localparam int LEFT_W =
    $clog2(cgra_conf_pkg::MAX_WORD_COUNT / cgra_conf_pkg::WORDS_PER_LINE + 2);

  logic [1:0]        state;
  logic [LEFT_W-1:0] lines_left;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= F_IDLE;
      mem_req    <= 1'b0;
      mem_addr   <= '0;
      push       <= 1'b0;
      lines_left <= '0;
    end else begin
      push <= 1'b0;
      case (state)
        F_IDLE: begin
          if (start) begin
            mem_req <= 1'b1;                     // Header request at address 0
            state   <= F_REQ;
          end
        end
        F_REQ: begin
          if (mem_ack) begin
            mem_req <= 1'b0;
            push    <= 1'b1;
            state   <= F_RELEASE;
            if (mem_addr == '0) begin
              lines_left <= LEFT_W'(
                cgra_conf_pkg::line_count(mem_line.header.word_count) - 32'd1);
            end else begin
              lines_left <= lines_left - 1'b1;
            end
          end
        end
        F_RELEASE: begin
          // Wait out the push cycle so that fifo_full is current
          if (!mem_ack && !push) begin
            if (lines_left == '0) begin
              state <= F_DONE;
            end else if (!fifo_full) begin
              mem_addr <= mem_addr + 1'b1;
              mem_req  <= 1'b1;
              state    <= F_REQ;
            end
          end
        end
        default: state <= F_DONE;                // Load complete, idle until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == F_REQ && mem_ack) begin
      push_line <= mem_line;
    end
  end

endmodule

//--- hdl/conf_line_fifo.sv
`timescale 1ns/1ps

module conf_line_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push,
  input  cgra_conf_pkg::conf_line_u  push_line,
  output logic                       full,
  input  logic                       pop,
  output logic                       empty,
  output logic                       rd_valid,
  output cgra_conf_pkg::conf_line_u  rd_line
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  cgra_conf_pkg::conf_line_u mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap explicitly so any depth works, not only powers of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // ##########################################################
  // Pointers and occupancy
  // ##########################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_pop;                        // Data follows the pop by one cycle
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_line;
    end
    if (do_pop) begin
      rd_line <= mem[rd_ptr];
    end
  end

endmodule

//--- hdl/cgra_control_conf.sv
`timescale 1ns/1ps

module cgra_control_conf #(
  parameter int DRAIN_CYCLES = 258
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               start,
  input  logic                               empty,
  output logic                               pop,
  input  logic                               rd_valid,
  input  cgra_conf_pkg::conf_line_u          rd_line,
  output logic [cgra_conf_pkg::WORD_W-1:0]   conf_bus,
  output logic                               conf_valid,
  output logic [7:0]                         read_fifo_mask,
  output logic [7:0]                         write_fifo_mask,
  output logic                               done
);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_REQ   = 3'd1;
  localparam logic [2:0] S_WAIT  = 3'd2;
  localparam logic [2:0] S_HDR   = 3'd3;
  localparam logic [2:0] S_SEND  = 3'd4;
  localparam logic [2:0] S_DRAIN = 3'd5;
  localparam logic [2:0] S_DONE  = 3'd6;

  localparam int CNT_W   = $clog2(cgra_conf_pkg::MAX_WORD_COUNT + 1);
  localparam int IDX_W   = $clog2(cgra_conf_pkg::WORDS_PER_LINE);
  localparam int DRAIN_W = $clog2(DRAIN_CYCLES + 2);

  logic [2:0]                 state;
  logic                       hdr_seen;
  cgra_conf_pkg::conf_line_u  line_q;
  logic [CNT_W-1:0]           word_total;
  logic [CNT_W-1:0]           word_cnt;
  logic [IDX_W-1:0]           word_idx;
  logic [DRAIN_W-1:0]         drain_cnt;
  logic                       last_word;

  assign pop       = (state == S_REQ) && !empty;   // One pop, then wait for the line
  assign last_word = (word_cnt + 1'b1 == word_total);

  // ##########################################################
  // Load sequence
  // ##########################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      state           <= S_IDLE;
      hdr_seen        <= 1'b0;
      word_total      <= '0;
      word_cnt        <= '0;
      word_idx        <= '0;
      drain_cnt       <= '0;
      conf_bus        <= '0;
      conf_valid      <= 1'b0;
      read_fifo_mask  <= '0;
      write_fifo_mask <= '0;
      done            <= 1'b0;
    end else begin
      conf_valid <= 1'b0;
      conf_bus   <= '0;                          // Bus idles at zero
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_REQ;
          end
        end
        S_REQ: begin
          if (!empty) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rd_valid) begin
            state <= hdr_seen ? S_SEND : S_HDR;
          end
        end
        S_HDR: begin
          hdr_seen        <= 1'b1;
          word_total      <= CNT_W'(cgra_conf_pkg::eff_count(line_q.header.word_count));
          read_fifo_mask  <= line_q.header.read_mask;
          write_fifo_mask <= line_q.header.write_mask;
          if (cgra_conf_pkg::eff_count(line_q.header.word_count) == '0) begin
            state <= S_DRAIN;                    // Nothing to send
          end else begin
            state <= S_REQ;
          end
        end
        S_SEND: begin
          conf_bus   <= line_q.words[word_idx];
          conf_valid <= 1'b1;
          word_cnt   <= word_cnt + 1'b1;
          if (last_word) begin
            state <= S_DRAIN;                    // Padding words of a partial line are dropped
          end else if (word_idx == IDX_W'(cgra_conf_pkg::WORDS_PER_LINE - 1)) begin
            word_idx <= '0;
            state    <= S_REQ;
          end else begin
            word_idx <= word_idx + 1'b1;
          end
        end
        S_DRAIN: begin
          if (drain_cnt == DRAIN_W'(DRAIN_CYCLES)) begin
            done  <= 1'b1;
            state <= S_DONE;
          end else begin
            drain_cnt <= drain_cnt + 1'b1;
          end
        end
        S_DONE: done <= 1'b1;                    // Held until reset
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_WAIT && rd_valid) begin
      line_q <= rd_line;
    end
  end

endmodule

//--- hdl/pe_conf_regs.sv
`timescale 1ns/1ps

module pe_conf_regs (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     conf_valid,
  input  logic [cgra_conf_pkg::WORD_W-1:0]         conf_bus,
  input  logic [cgra_arch_pkg::PE_ID_W-1:0]        rd_pe,
  output logic [cgra_arch_pkg::PE_PAYLOAD_W-1:0]   rd_conf
);

  localparam int IDX_W = cgra_arch_pkg::PE_IDX_W;
  localparam int PAY_W = cgra_arch_pkg::PE_PAYLOAD_W;

  logic [PAY_W-1:0]                  regs [cgra_arch_pkg::NUM_PE];
  logic [cgra_arch_pkg::PE_ID_W-1:0] wr_pe;
  logic [PAY_W-1:0]                  wr_data;
  logic                              wr_hit;
  logic                              rd_hit;

  assign wr_pe   = conf_bus[cgra_conf_pkg::WORD_W-1 -: cgra_arch_pkg::PE_ID_W];
  assign wr_data = conf_bus[PAY_W-1:0];

  // Ids past the array are broadcast but land nowhere
  assign wr_hit = conf_valid && (wr_pe < cgra_arch_pkg::PE_ID_W'(cgra_arch_pkg::NUM_PE));
  assign rd_hit = (rd_pe < cgra_arch_pkg::PE_ID_W'(cgra_arch_pkg::NUM_PE));

  // ##########################################################
  // Register bank
  // ##########################################################

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < cgra_arch_pkg::NUM_PE; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_hit) begin
      regs[wr_pe[IDX_W-1:0]] <= wr_data;         // Last word for a PE wins
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_conf <= '0;
    end else if (rd_hit) begin
      rd_conf <= regs[rd_pe[IDX_W-1:0]];
    end else begin
      rd_conf <= '0;
    end
  end

endmodule

//--- hdl/cgra_conf_top.sv
`timescale 1ns/1ps

module cgra_conf_top #(
  parameter int FIFO_DEPTH   = 4,
  parameter int DRAIN_CYCLES = 258,
  parameter int ADDR_W       = 16
) (
  input  logic                                     clk,
  input  logic                                     rst,
  input  logic                                     start,
  input  logic                                     mem_ack,
  output logic                                     mem_req,
  output logic [ADDR_W-1:0]                        mem_addr,
  input  cgra_conf_pkg::conf_line_u                mem_line,
  output logic [cgra_conf_pkg::WORD_W-1:0]         conf_bus,
  output logic                                     conf_valid,
  output logic [7:0]                               read_fifo_mask,
  output logic [7:0]                               write_fifo_mask,
  output logic                                     done,
  input  logic [cgra_arch_pkg::PE_ID_W-1:0]        rd_pe,
  output logic [cgra_arch_pkg::PE_PAYLOAD_W-1:0]   rd_conf
);

  logic                      push;
  cgra_conf_pkg::conf_line_u push_line;
  logic                      fifo_full;
  logic                      fifo_empty;
  logic                      pop;
  logic                      rd_valid;
  cgra_conf_pkg::conf_line_u rd_line;

  conf_line_fetch #(
    .ADDR_W(ADDR_W)
  ) u_fetch (
    .clk(clk), .rst(rst), .start(start),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack), .mem_line(mem_line),
    .push(push), .push_line(push_line), .fifo_full(fifo_full)
  );

  conf_line_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk(clk), .rst(rst), .push(push), .push_line(push_line), .full(fifo_full),
    .pop(pop), .empty(fifo_empty), .rd_valid(rd_valid), .rd_line(rd_line)
  );

  cgra_control_conf #(
    .DRAIN_CYCLES(DRAIN_CYCLES)
  ) u_ctrl (
    .clk(clk), .rst(rst), .start(start), .empty(fifo_empty), .pop(pop),
    .rd_valid(rd_valid), .rd_line(rd_line), .conf_bus(conf_bus), .conf_valid(conf_valid),
    .read_fifo_mask(read_fifo_mask), .write_fifo_mask(write_fifo_mask), .done(done)
  );

  pe_conf_regs u_regs (
    .clk(clk), .rst(rst), .conf_valid(conf_valid), .conf_bus(conf_bus),
    .rd_pe(rd_pe), .rd_conf(rd_conf)
  );

endmodule

//--- test/cgra_conf_chk.sv
`timescale 1ns/1ps

module cgra_conf_chk #(
  parameter int ADDR_W = 16
) (
  input logic                             clk,
  input logic                             rst,
  input logic                             mem_req,
  input logic                             mem_ack,
  input logic [ADDR_W-1:0]                mem_addr,
  input logic                             conf_valid,
  input logic [cgra_conf_pkg::WORD_W-1:0] conf_bus,
  input logic                             pop,
  input logic                             empty
);

  int fail_count = 0;                            // Summed into the testbench totals

  function automatic void record_failure(input string what);
    fail_count++;
    $error("%s", what);
  endfunction

  // ##########################################################
  // Memory handshake
  // ##########################################################

  assert property (@(posedge clk) disable iff (rst) mem_req && !mem_ack |=> mem_req)
    else record_failure("mem_req dropped before mem_ack");
  assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req || $stable(mem_addr))
    else record_failure("mem_addr changed while mem_req was high");
  assert property (@(posedge clk) disable iff (rst) $rose(mem_req) |-> !mem_ack)
    else record_failure("new request started while mem_ack was still high");

  // ##########################################################
  // Configuration bus and FIFO pop
  // ##########################################################

  assert property (@(posedge clk) disable iff (rst) !conf_valid |-> conf_bus == '0)
    else record_failure("conf_bus not zero while conf_valid was low");
  assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
    else record_failure("pop issued while the FIFO was empty");

endmodule

// Unused checker inputs are tied off in each scope
bind conf_line_fetch cgra_conf_chk #(.ADDR_W(ADDR_W)) i_chk (
  .clk(clk), .rst(rst), .mem_req(mem_req), .mem_ack(mem_ack), .mem_addr(mem_addr),
  .conf_valid(1'b0), .conf_bus('0), .pop(1'b0), .empty(1'b0)
);

bind cgra_control_conf cgra_conf_chk i_chk (
  .clk(clk), .rst(rst), .mem_req(1'b0), .mem_ack(1'b0), .mem_addr('0),
  .conf_valid(conf_valid), .conf_bus(conf_bus), .pop(pop), .empty(empty)
);

//--- test/cgra_conf_tb.sv
`timescale 1ns/1ps

module cgra_conf_tb;

  localparam int FIFO_DEPTH   = 4;
  localparam int DRAIN_CYCLES = 258;
  localparam int ADDR_W       = 16;
  localparam int NUM_PE       = cgra_arch_pkg::NUM_PE;

  logic                                   clk;
  logic                                   rst;
  logic                                   start;
  logic                                   mem_ack;
  logic                                   mem_req;
  logic [ADDR_W-1:0]                      mem_addr;
  cgra_conf_pkg::conf_line_u              mem_line;
  logic [cgra_conf_pkg::WORD_W-1:0]       conf_bus;
  logic                                   conf_valid;
  logic [7:0]                             read_fifo_mask;
  logic [7:0]                             write_fifo_mask;
  logic                                   done;
  logic [cgra_arch_pkg::PE_ID_W-1:0]      rd_pe;
  logic [cgra_arch_pkg::PE_PAYLOAD_W-1:0] rd_conf;

  // Word count, memory speed and header masks of each load
  int         test_words [5] = '{20, 0, 16, 7, 400};
  bit         test_slow  [5] = '{0, 0, 0, 0, 1};
  logic [7:0] test_rmask [5] = '{8'ha5, 8'h0f, 8'hff, 8'h01, 8'h3c};
  logic [7:0] test_wmask [5] = '{8'h5a, 8'hf0, 8'h00, 8'h80, 8'hc3};

  logic [cgra_conf_pkg::LINE_W-1:0] mem_img [64];
  int unsigned                      ack_delay [64];
  logic [63:0]                      words [$];
  logic [63:0]                      exp_stream [$];
  logic [55:0]                      exp_pe [NUM_PE];
  logic [7:0]                       exp_rmask;
  logic [7:0]                       exp_wmask;
  int  seen_words;
  int  req_count;
  int  errors = 0;
  int  checks = 0;
  int  cycles = 0;
  int  cycle_limit = 0;
  logic req_prev;
  logic done_prev;
  bit   full_seen;

  cgra_conf_top #(
    .FIFO_DEPTH(FIFO_DEPTH), .DRAIN_CYCLES(DRAIN_CYCLES), .ADDR_W(ADDR_W)
  ) i_dut (
    .clk(clk), .rst(rst), .start(start), .mem_ack(mem_ack), .mem_req(mem_req),
    .mem_addr(mem_addr), .mem_line(mem_line), .conf_bus(conf_bus), .conf_valid(conf_valid),
    .read_fifo_mask(read_fifo_mask), .write_fifo_mask(write_fifo_mask), .done(done),
    .rd_pe(rd_pe), .rd_conf(rd_conf)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  function automatic int assertion_failures();
    return i_dut.u_fetch.i_chk.fail_count + i_dut.u_ctrl.i_chk.fail_count;
  endfunction

  task automatic print_summary();
    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
             checks, errors, assertion_failures());
  endtask

  // Unused line slots carry a pattern made from line and slot
  function automatic logic [63:0] fill_word(input int line, input int slot);
    return {8'hee, 24'(line) ^ 24'h5a5a5a, 24'(slot * 7 + line), 8'h11};
  endfunction

  function automatic void ref_model(input logic [7:0] rmask, input logic [7:0] wmask);
    logic [7:0] id;
    exp_rmask = rmask;
    exp_wmask = wmask;
    exp_stream.delete();
    foreach (exp_pe[i]) begin
      exp_pe[i] = '0;
    end
    foreach (words[i]) begin
      exp_stream.push_back(words[i]);
      id = words[i][63:56];
      if (id < NUM_PE) begin
        exp_pe[id] = words[i][55:0];             // Later words overwrite earlier ones
      end
    end
  endfunction

  task automatic build_image(input int n_words, input logic [7:0] rmask,
                             input logic [7:0] wmask, input bit slow);
    words.delete();
    for (int a = 0; a < 64; a++) begin
      for (int s = 0; s < 8; s++) begin
        mem_img[a][s*64 +: 64] = fill_word(a, s);
      end
      ack_delay[a] = slow ? 3 + $urandom % 3 : $urandom % 6;
    end
    mem_img[0][31:0]  = 32'(n_words);
    mem_img[0][39:32] = rmask;
    mem_img[0][71:64] = wmask;
    for (int i = 0; i < n_words; i++) begin
      words.push_back({8'($urandom % 20), 24'($urandom), 32'($urandom)});
      mem_img[1 + i / 8][(i % 8) * 64 +: 64] = words[i];
    end
  endtask

  task automatic run_load(input int n_words, input logic [7:0] rmask,
                          input logic [7:0] wmask, input bit slow);
    build_image(n_words, rmask, wmask, slow);
    ref_model(rmask, wmask);
    @(posedge clk);
    rst <= 1'b1;
    repeat (10) @(posedge clk);
    rst   <= 1'b0;
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!done) @(negedge clk);
    @(posedge clk);
    check_eq("read_fifo_mask", read_fifo_mask, exp_rmask);
    check_eq("write_fifo_mask", write_fifo_mask, exp_wmask);
    check_eq("mem_req count", 64'(req_count), 64'(1 + (n_words + 7) / 8));
    check_eq("conf word count", 64'(seen_words), 64'(n_words));
    if (slow && !full_seen) begin
      errors++;
      $display("At %0t the line FIFO never filled during the slow load", $time);
    end
    for (int p = 0; p <= NUM_PE; p++) begin
      rd_pe <= 8'(p);
      @(posedge clk);
      @(negedge clk);
      check_eq($sformatf("rd_conf[%0d]", p), rd_conf, (p < NUM_PE) ? exp_pe[p] : 56'(0));
      @(posedge clk);
    end
  endtask

  // ##########################################################
  // Memory model, compare process and timeout
  // ##########################################################

  initial begin
    forever begin
      @(posedge clk);
      if (!rst && mem_req && !mem_ack) begin
        repeat (ack_delay[mem_addr]) @(posedge clk);
        mem_line <= mem_img[mem_addr];
        mem_ack  <= 1'b1;
        while (mem_req) @(posedge clk);
        mem_ack <= 1'b0;
      end
    end
  end

  always @(negedge clk) begin
    if (rst) begin
      seen_words = 0;
      req_count  = 0;
      req_prev   = 1'b0;
      done_prev  = 1'b0;
      full_seen  = 1'b0;
    end else begin
      if (mem_req && !req_prev) begin
        check_eq("mem_addr", 64'(mem_addr), 64'(req_count));   // Requests walk up from 0
        req_count++;
      end
      if (i_dut.fifo_full) begin
        full_seen = 1'b1;                        // Memory side is being held back
      end
      if (conf_valid) begin
        if (seen_words < exp_stream.size()) begin
          check_eq("conf_bus", conf_bus, exp_stream[seen_words]);
        end else begin
          errors++;
          $display("At %0t conf_bus carried a word past the word count", $time);
        end
        seen_words++;
      end
      if (done && !done_prev) begin
        check_eq("words before done", 64'(seen_words), 64'(exp_stream.size()));
      end
      req_prev  = mem_req;
      done_prev = done;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      print_summary();
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    int lines;
    void'($urandom(95));
    rst      = 1'b1;
    start    = 1'b0;
    mem_ack  = 1'b0;
    mem_line = '0;
    rd_pe    = '0;
    foreach (test_words[t]) begin
      lines = 1 + (test_words[t] + 7) / 8;
      cycle_limit += lines * 12 + test_words[t] + DRAIN_CYCLES + 50;
    end
    foreach (test_words[t]) begin
      run_load(test_words[t], test_rmask[t], test_wmask[t], test_slow[t]);
    end
    print_summary();
    if (errors == 0 && assertion_failures() == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verilog.f
hdl/cgra_conf_pkg.sv
hdl/cgra_arch_pkg.sv
hdl/conf_line_fetch.sv
hdl/conf_line_fifo.sv
hdl/cgra_control_conf.sv
hdl/pe_conf_regs.sv
hdl/cgra_conf_top.sv
test/cgra_conf_chk.sv
test/cgra_conf_tb.sv

//--- Bender.yml
package:
  name: cgra_conf

sources:
  - files:
      - hdl/cgra_conf_pkg.sv
      - hdl/cgra_arch_pkg.sv
      - hdl/conf_line_fetch.sv
      - hdl/conf_line_fifo.sv
      - hdl/cgra_control_conf.sv
      - hdl/pe_conf_regs.sv
      - hdl/cgra_conf_top.sv
  - target: test
    files:
      - test/cgra_conf_chk.sv
      - test/cgra_conf_tb.sv
